// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module sample_buffer_tb \
  -f sample_buffer.f \
  -o sim_sample_buffer

./obj_dir/sim_sample_buffer | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0

// ==== sample_buffer.f ====
verilog/sample_buffer_pkg.sv
verilog/bank_port_if.sv
verilog/capture_control.sv
verilog/sample_bank.sv
verilog/bank_readout.sv
verilog/sample_buffer.sv
tb/sample_buffer_tb.sv

// ==== tb/sample_buffer_tb.sv ====
// testbench for the banked sample buffer: random stimulus, reference model and stream check
`default_nettype none

module sample_buffer_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import sample_buffer_pkg::*;

  localparam int CHANNELS   = 4;
  localparam int BANK_DEPTH = 32;
  // about 3000 cycles of tests, with a wide margin
  localparam int MAX_CYCLES = 40000;
  localparam int NO_STOP    = 2147483647;

  logic                               clk;
  logic                               reset;
  logic [CHANNELS*SAMPLE_WIDTH-1:0]   data_in_data;
  logic [CHANNELS-1:0]                data_in_valid;
  mode_t                              config_data;
  logic                               config_valid;
  logic                               config_ready;
  logic [1:0]                         start_stop_data;
  logic                               start_stop_valid;
  logic                               start_stop_ready;
  logic                               start_aux;
  logic                               stop_aux;
  sample_t                            data_out_data;
  logic                               data_out_valid;
  logic                               data_out_last;
  logic                               data_out_ready;
  logic                               capture_started;
  logic                               buffer_full;

  logic [31:0]                        lfsr;
  int                                 cyc;
  int                                 start_cyc;
  int                                 stop_cyc;
  int                                 log_cyc [$];
  logic [CHANNELS-1:0]                log_valid [$];
  logic [CHANNELS*SAMPLE_WIDTH-1:0]   log_data [$];
  sample_t                            exp_data [$];
  logic                               exp_full;
  int                                 got_n;
  logic                               got_last;
  int                                 cmp_errors;
  int                                 chk_errors;
  int                                 test_count;
  int                                 failed_tests;

  sample_buffer #(
    .CHANNELS  (CHANNELS),
    .BANK_DEPTH(BANK_DEPTH)
  ) DUT (
    .clk             (clk),
    .reset           (reset),
    .data_in_data    (data_in_data),
    .data_in_valid   (data_in_valid),
    .config_data     (config_data),
    .config_valid    (config_valid),
    .config_ready    (config_ready),
    .start_stop_data (start_stop_data),
    .start_stop_valid(start_stop_valid),
    .start_stop_ready(start_stop_ready),
    .start_aux       (start_aux),
    .stop_aux        (stop_aux),
    .data_out_data   (data_out_data),
    .data_out_valid  (data_out_valid),
    .data_out_last   (data_out_last),
    .data_out_ready  (data_out_ready),
    .capture_started (capture_started),
    .buffer_full     (buffer_full)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic drive_samples(input bit rand_valid);
    logic [31:0] v;
    for (int c = 0; c < CHANNELS; c++) begin
      take_bits(SAMPLE_WIDTH, v);
      data_in_data[c*SAMPLE_WIDTH +: SAMPLE_WIDTH] = v[SAMPLE_WIDTH-1:0];
    end
    if (rand_valid) begin
      take_bits(CHANNELS, v);
      data_in_valid = v[CHANNELS-1:0];
    end else begin
      data_in_valid = '1;
    end
  endtask

  // cycle count, timeout and the input log of the current capture
  always @(posedge clk) begin
    cyc++;
    if (cyc > MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end else if (!reset) begin
      if ((start_stop_valid && start_stop_data[1]) || start_aux) begin
        log_cyc.delete();
        log_valid.delete();
        log_data.delete();
        start_cyc = cyc;
        stop_cyc  = NO_STOP;
      end
      if ((start_stop_valid && start_stop_data[0]) || stop_aux) begin
        stop_cyc = cyc;
      end
      if (|data_in_valid) begin
        log_cyc.push_back(cyc);
        log_valid.push_back(data_in_valid);
        log_data.push_back(data_in_data);
      end
    end
  end

  // replay the log: channel c fills banks c, c+2^m, ... and the fill edge is kept
  function automatic void build_expected(input int m);
    int      nch;
    int      cap;
    int      b;
    int      ch_cnt [CHANNELS];
    int      bank_len [CHANNELS];
    sample_t bank_mem [CHANNELS][BANK_DEPTH];
    logic    filled;
    nch    = 1 << m;
    cap    = (CHANNELS / nch) * BANK_DEPTH;
    filled = 1'b0;
    for (int c = 0; c < CHANNELS; c++) begin
      ch_cnt[c]   = 0;
      bank_len[c] = 0;
    end
    for (int i = 0; i < log_cyc.size() && !filled; i++) begin
      if (log_cyc[i] > start_cyc && log_cyc[i] <= stop_cyc) begin
        for (int c = 0; c < nch; c++) begin
          if (log_valid[i][c] && ch_cnt[c] < cap) begin
            b = c + (ch_cnt[c] / BANK_DEPTH) * nch;
            bank_mem[b][bank_len[b]] = log_data[i][c*SAMPLE_WIDTH +: SAMPLE_WIDTH];
            bank_len[b]++;
            ch_cnt[c]++;
            if (ch_cnt[c] == cap) begin
              filled = 1'b1;
            end
          end
        end
      end
    end
    exp_full = filled;
    exp_data.delete();
    for (int k = 0; k < CHANNELS; k++) begin
      exp_data.push_back(sample_t'(k % nch));
      exp_data.push_back(sample_t'(bank_len[k]));
      for (int s = 0; s < bank_len[k]; s++) begin
        exp_data.push_back(bank_mem[k][s]);
      end
    end
  endfunction

  // checks every output transfer against the expected stream
  always @(posedge clk) begin
    if (capture_started) begin
      got_n    = 0;
      got_last = 1'b0;
    end else if (!reset && data_out_valid && data_out_ready) begin
      if (got_n >= exp_data.size()) begin
        $display("FAILED %0t: unexpected word %h after the stream", $time, data_out_data);
        cmp_errors++;
      end else begin
        if (data_out_data !== exp_data[got_n]) begin
          $display("FAILED %0t: word %0d is %h, expected %h", $time, got_n,
                   data_out_data, exp_data[got_n]);
          cmp_errors++;
        end
        if (data_out_last !== (got_n == exp_data.size() - 1)) begin
          $display("FAILED %0t: last is %b on word %0d", $time, data_out_last, got_n);
          cmp_errors++;
        end
      end
      if (data_out_last) begin
        got_last = 1'b1;
      end
      got_n++;
    end
  end

  task automatic run_test(input string name, input int m, input int n, input bit rand_valid,
                          input bit rand_ready, input bit use_aux, input bit cfg_during);
    int          errs_before;
    logic [31:0] v;
    errs_before = chk_errors + cmp_errors;
    while (!config_ready) begin
      @(posedge clk);
      #2;
    end
    config_data  = mode_t'(m);
    config_valid = 1'b1;
    @(posedge clk);
    #2;
    config_valid = 1'b0;
    // samples on the start edge come before capture and are dropped
    if (use_aux) begin
      start_aux = 1'b1;
    end else begin
      start_stop_valid = 1'b1;
      start_stop_data  = 2'b10;
      if (!start_stop_ready) begin
        $display("FAILED %0t: start_stop_ready is low with a start command", $time);
        chk_errors++;
      end
    end
    drive_samples(rand_valid);
    @(posedge clk);
    #2;
    start_aux        = 1'b0;
    start_stop_valid = 1'b0;
    if (!capture_started) begin
      $display("FAILED %0t: capture did not start one cycle after the start", $time);
      chk_errors++;
    end
    for (int i = 0; i < n && capture_started; i++) begin
      if (cfg_during) begin
        config_data  = '0;
        config_valid = (i >= 2 && i < 5);
        if (config_ready) begin
          $display("FAILED %0t: config_ready is high during capture", $time);
          chk_errors++;
        end
      end
      drive_samples(rand_valid);
      @(posedge clk);
      #2;
    end
    config_valid = 1'b0;
    if (capture_started) begin
      if (use_aux) begin
        stop_aux = 1'b1;
      end else begin
        start_stop_valid = 1'b1;
        start_stop_data  = 2'b01;
      end
      drive_samples(rand_valid);
      @(posedge clk);
      #2;
      stop_aux         = 1'b0;
      start_stop_valid = 1'b0;
      if (capture_started) begin
        $display("FAILED %0t: capture still running after the stop edge", $time);
        chk_errors++;
      end
    end
    data_in_valid = '0;
    while (capture_started) begin
      @(posedge clk);
      #2;
    end
    build_expected(m);
    if (buffer_full !== exp_full) begin
      $display("FAILED %0t: buffer_full is %b, expected %b", $time, buffer_full, exp_full);
      chk_errors++;
    end
    while (!got_last) begin
      if (rand_ready) begin
        take_bits(1, v);
        data_out_ready = v[0];
      end
      @(posedge clk);
      #2;
    end
    data_out_ready = 1'b1;
    while (!config_ready) begin
      @(posedge clk);
      #2;
    end
    if (got_n != exp_data.size()) begin
      $display("FAILED %0t: %0d words received, expected %0d", $time, got_n, exp_data.size());
      chk_errors++;
    end
    if (buffer_full) begin
      $display("FAILED %0t: buffer_full still high in idle", $time);
      chk_errors++;
    end
    test_count++;
    if (chk_errors + cmp_errors != errs_before) begin
      failed_tests++;
    end
    $display("test %0d %s, mode %0d: %s, %0d words", test_count, name, m,
             (chk_errors + cmp_errors == errs_before) ? "passed" : "failed", got_n);
  endtask

  initial begin
    lfsr             = 32'h6bd65efd;
    cyc              = 0;
    start_cyc        = 0;
    stop_cyc         = NO_STOP;
    got_n            = 0;
    got_last         = 1'b0;
    cmp_errors       = 0;
    chk_errors       = 0;
    test_count       = 0;
    failed_tests     = 0;
    reset            = 1'b1;
    data_in_data     = '0;
    data_in_valid    = '0;
    config_data      = '0;
    config_valid     = 1'b0;
    start_stop_data  = 2'b00;
    start_stop_valid = 1'b0;
    start_aux        = 1'b0;
    stop_aux         = 1'b0;
    data_out_ready   = 1'b1;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    if (data_out_valid || capture_started || buffer_full || !config_ready) begin
      $display("FAILED %0t: outputs are not in their reset state", $time);
      chk_errors++;
    end

    for (int m = 0; m <= 2; m++) begin
      run_test("few samples", m, 5, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    for (int m = 0; m <= 2; m++) begin
      run_test("exact fill", m, (CHANNELS >> m) * BANK_DEPTH, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    for (int m = 0; m <= 2; m++) begin
      run_test("random valid overfill", m, 3 * (CHANNELS >> m) * BANK_DEPTH,
               1'b1, 1'b0, 1'b0, 1'b0);
    end
    run_test("random ready", 2, 20, 1'b1, 1'b1, 1'b0, 1'b0);
    run_test("random ready with fill", 0, 3 * CHANNELS * BANK_DEPTH, 1'b1, 1'b1, 1'b0, 1'b0);
    run_test("aux start and stop, config in capture", 1, 10, 1'b0, 1'b0, 1'b1, 1'b1);

    $display("tests %0d, failed tests %0d, errors %0d", test_count, failed_tests,
             chk_errors + cmp_errors);
    if (failed_tests == 0 && chk_errors + cmp_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/bank_port_if.sv ====
// bank port interface carrying one bank's read address, strobe, data and fill count
`default_nettype none

interface bank_port_if #(
  parameter int BANK_DEPTH = 32
);
  import sample_buffer_pkg::*;

  logic                            rd_en;
  logic [$clog2(BANK_DEPTH)-1:0]   rd_addr;
  sample_t                         rd_data;
  logic [$clog2(BANK_DEPTH+1)-1:0] count;

  modport bank (
    input  rd_en,
    input  rd_addr,
    output rd_data,
    output count
  );

  modport reader (
    output rd_en,
    output rd_addr,
    input  rd_data,
    input  count
  );

endinterface

`default_nettype wire

// ==== verilog/bank_readout.sv ====
// bank readout: streams header, count and samples of every bank through a two-entry skid buffer
`default_nettype none

module bank_readout #(
  parameter int CHANNELS   = 4,
  parameter int BANK_DEPTH = 32
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       readout_start,
  input  sample_buffer_pkg::mode_t   mode,
  bank_port_if.reader                banks [CHANNELS],
  output sample_buffer_pkg::sample_t data_out_data,
  output logic                       data_out_valid,
  output logic                       data_out_last,
  input  logic                       data_out_ready,
  output logic                       readout_done
);
  import sample_buffer_pkg::*;

  localparam int ADDR_W = $clog2(BANK_DEPTH);
  localparam int CNT_W  = $clog2(BANK_DEPTH + 1);
  localparam int BANK_W = $clog2(CHANNELS);

  sample_t          rd_data_arr [CHANNELS];
  logic [CNT_W-1:0] count_arr [CHANNELS];

  logic              active;
  logic [BANK_W-1:0] bank_idx;
  word_kind_t        kind;
  logic [ADDR_W-1:0] samp_idx;
  logic [CNT_W-1:0]  cur_count;
  logic              issue;
  logic              last_of_bank;
  logic              final_word;
  sample_t           issue_word;

  logic              pipe_valid;
  word_kind_t        pipe_kind;
  sample_t           pipe_word;
  logic              pipe_last;
  logic [BANK_W-1:0] pipe_bank;

  sample_t    fifo_data [2];
  logic [1:0] fifo_last;
  logic [1:0] fifo_cnt;
  logic       wr_ptr;
  logic       rd_ptr;
  logic       pop;

  for (genvar b = 0; b < CHANNELS; b++) begin : g_port
    assign banks[b].rd_en   = issue && (kind == wk_sample) && (bank_idx == BANK_W'(b));
    assign banks[b].rd_addr = samp_idx;
    assign rd_data_arr[b]   = banks[b].rd_data;
    assign count_arr[b]     = banks[b].count;
  end

  assign cur_count = count_arr[bank_idx];
  assign pop       = data_out_valid && data_out_ready;

  // a word issued now lands in the skid buffer next cycle, so reserve room for it
  assign issue = (active || readout_start)
                 && ({1'b0, fifo_cnt} + 3'(pipe_valid) < 3'd2 + 3'(pop));

  assign last_of_bank = (kind == wk_count && cur_count == '0)
                        || (kind == wk_sample && CNT_W'(samp_idx) == cur_count - CNT_W'(1));
  assign final_word   = last_of_bank && (bank_idx == BANK_W'(CHANNELS - 1));

  always_comb begin
    if (kind == wk_header) begin
      issue_word = SAMPLE_WIDTH'(bank_idx & BANK_W'((1 << mode) - 1));
    end else begin
      issue_word = SAMPLE_WIDTH'(cur_count);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      active   <= 1'b0;
      bank_idx <= '0;
      kind     <= wk_header;
      samp_idx <= '0;
    end else if (issue) begin
      active <= !final_word;
      if (kind == wk_header) begin
        kind <= wk_count;
      end else if (last_of_bank) begin
        bank_idx <= final_word ? '0 : bank_idx + BANK_W'(1);
        kind     <= wk_header;
        samp_idx <= '0;
      end else if (kind == wk_count) begin
        kind <= wk_sample;
      end else begin
        samp_idx <= samp_idx + ADDR_W'(1);
      end
    end
  end

  // one cycle stage matching the synchronous bank read
  always_ff @(posedge clk) begin
    if (reset) begin
      pipe_valid <= 1'b0;
    end else begin
      pipe_valid <= issue;
    end
    if (issue) begin
      pipe_kind <= kind;
      pipe_word <= issue_word;
      pipe_last <= final_word;
      pipe_bank <= bank_idx;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fifo_cnt <= '0;
      wr_ptr   <= 1'b0;
      rd_ptr   <= 1'b0;
    end else begin
      fifo_cnt <= fifo_cnt + 2'(pipe_valid) - 2'(pop);
      if (pipe_valid) begin
        wr_ptr <= !wr_ptr;
      end
      if (pop) begin
        rd_ptr <= !rd_ptr;
      end
    end
    if (pipe_valid) begin
      fifo_data[wr_ptr] <= (pipe_kind == wk_sample) ? rd_data_arr[pipe_bank] : pipe_word;
      fifo_last[wr_ptr] <= pipe_last;
    end
  end

  assign data_out_valid = (fifo_cnt != '0);
  assign data_out_data  = fifo_data[rd_ptr];
  assign data_out_last  = fifo_last[rd_ptr];
  assign readout_done   = pop && data_out_last;

  assert property (@(posedge clk) disable iff (reset)
    data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out_data));

endmodule

`default_nettype wire

// ==== verilog/capture_control.sv ====
// capture controller: mode and start/stop handling, idle/capture/readout FSM, bank segments
`default_nettype none

module capture_control #(
  parameter int CHANNELS   = 4,
  parameter int BANK_DEPTH = 32
) (
  input  logic                     clk,
  input  logic                     reset,
  input  sample_buffer_pkg::mode_t config_data,
  input  logic                     config_valid,
  output logic                     config_ready,
  input  logic [1:0]               start_stop_data,
  input  logic                     start_stop_valid,
  output logic                     start_stop_ready,
  input  logic                     start_aux,
  input  logic                     stop_aux,
  input  logic [CHANNELS-1:0]      bank_full,
  input  logic                     readout_done,
  output sample_buffer_pkg::mode_t mode,
  output logic                     capture_en,
  output logic [CHANNELS-1:0]      seg_active,
  output logic                     readout_start,
  output logic                     capture_started,
  output logic                     buffer_full
);
  import sample_buffer_pkg::*;

  localparam int PTR_W    = $clog2(CHANNELS);
  localparam int MODE_MAX = $clog2(CHANNELS);

  // bank and channel arithmetic below relies on masks
  if ((CHANNELS & (CHANNELS - 1)) != 0 || (BANK_DEPTH & (BANK_DEPTH - 1)) != 0) begin : g_check
    $error("CHANNELS and BANK_DEPTH must be powers of two");
  end

  ctrl_state_t         state;
  cmd_t                cmd;
  logic                start_cmd;
  logic                stop_cmd;
  logic                fill;
  logic [CHANNELS-1:0] advance;
  logic [PTR_W-1:0]    seg_ptr [CHANNELS];

  assign cmd       = cmd_t'(start_stop_data);
  assign start_cmd = (start_stop_valid && cmd.start) || start_aux;
  assign stop_cmd  = (start_stop_valid && cmd.stop) || stop_aux;

  assign config_ready     = (state == st_idle);
  assign start_stop_ready = 1'b1;
  assign capture_en       = (state == st_capture);
  assign capture_started  = capture_en;

  // bank b belongs to channel b mod 2^mode as segment b >> mode
  always_comb begin
    int ch;
    for (int b = 0; b < CHANNELS; b++) begin
      ch = b & ((1 << mode) - 1);
      seg_active[b] = (int'(seg_ptr[ch]) == (b >> mode));
    end
  end

  // a channel moves on when its active bank fills, except in its last segment
  always_comb begin
    int bidx;
    for (int c = 0; c < CHANNELS; c++) begin
      bidx = c + (int'(seg_ptr[c]) << mode);
      advance[c] = (c < (1 << mode)) && (bidx < CHANNELS) && bank_full[bidx]
                   && (int'(seg_ptr[c]) < (CHANNELS >> mode) - 1);
    end
  end

  // last segments are the top 2^mode banks
  always_comb begin
    fill = 1'b0;
    for (int b = 0; b < CHANNELS; b++) begin
      if (b >= CHANNELS - (1 << mode) && bank_full[b]) begin
        fill = 1'b1;
      end
    end
    fill = fill && capture_en;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= st_idle;
      mode          <= '0;
      readout_start <= 1'b0;
      buffer_full   <= 1'b0;
    end else begin
      readout_start <= 1'b0;
      case (state)
        st_idle: begin
          if (config_valid) begin
            mode <= (config_data > mode_t'(MODE_MAX)) ? mode_t'(MODE_MAX) : config_data;
          end
          if (start_cmd) begin
            state <= st_capture;
          end
        end
        st_capture: begin
          // writes on this edge still land in the banks
          if (stop_cmd || fill) begin
            state         <= st_readout;
            readout_start <= 1'b1;
          end
          if (fill) begin
            buffer_full <= 1'b1;
          end
        end
        st_readout: begin
          if (readout_done) begin
            state       <= st_idle;
            buffer_full <= 1'b0;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    for (int c = 0; c < CHANNELS; c++) begin
      if (reset || (state == st_idle && start_cmd)) begin
        seg_ptr[c] <= '0;
      end else if (capture_en && advance[c]) begin
        seg_ptr[c] <= seg_ptr[c] + PTR_W'(1);
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    config_ready |-> !buffer_full);

  // the mode only changes on a config accepted in idle
  assert property (@(posedge clk) disable iff (reset)
    !config_ready |=> $stable(mode));

  // exactly one active bank for each enabled channel
  assert property (@(posedge clk) disable iff (reset)
    capture_en |-> $countones(seg_active) == (1 << mode));

endmodule

`default_nettype wire

// ==== verilog/sample_bank.sv ====
// sample bank: one memory segment that captures its channel and serves synchronous reads
`default_nettype none

module sample_bank #(
  parameter int CHANNELS   = 4,
  parameter int BANK_DEPTH = 32,
  parameter int BANK_INDEX = 0
) (
  input  logic                                            clk,
  input  logic                                            reset,
  input  logic [CHANNELS*sample_buffer_pkg::SAMPLE_WIDTH-1:0] data_in_data,
  input  logic [CHANNELS-1:0]                             data_in_valid,
  input  sample_buffer_pkg::mode_t                        mode,
  input  logic                                            capture_en,
  input  logic                                            seg_active,
  input  logic                                            readout_start,
  bank_port_if.bank                                       rd,
  output logic                                            full
);
  import sample_buffer_pkg::*;

  localparam int ADDR_W = $clog2(BANK_DEPTH);
  localparam int CNT_W  = $clog2(BANK_DEPTH + 1);

  sample_t          mem [BANK_DEPTH];
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] eff_count;
  logic             stale;
  logic             at_depth;
  logic             wr;
  sample_t          wr_data;
  int               ch;

  // channel served by this bank under the current mode
  always_comb begin
    ch      = BANK_INDEX & ((1 << mode) - 1);
    wr_data = data_in_data[ch*SAMPLE_WIDTH +: SAMPLE_WIDTH];
  end

  // contents handed to readout count as empty once capture restarts
  assign eff_count = stale ? '0 : count;
  assign at_depth  = (eff_count == CNT_W'(BANK_DEPTH));
  assign wr        = capture_en && seg_active && data_in_valid[ch] && !at_depth;

  // also high on the write that fills, so the controller acts on the same edge
  assign full = at_depth || (wr && eff_count == CNT_W'(BANK_DEPTH - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      stale <= 1'b0;
    end else if (readout_start) begin
      stale <= 1'b1;
    end else if (capture_en) begin
      stale <= 1'b0;
      count <= eff_count + CNT_W'(wr);
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[eff_count[ADDR_W-1:0]] <= wr_data;
    end
    if (rd.rd_en) begin
      rd.rd_data <= mem[rd.rd_addr];
    end
  end

  assign rd.count = count;

  // once full, the controller moves the channel on or ends capture
  assert property (@(posedge clk) disable iff (reset)
    full && capture_en |=> !(capture_en && seg_active));

endmodule

`default_nettype wire

// ==== verilog/sample_buffer.sv ====
// banked sample buffer top: capture controller, per-channel memory banks and readout
`default_nettype none

module sample_buffer #(
  parameter int CHANNELS   = 4,
  parameter int BANK_DEPTH = 32
) (
  input  logic                                                clk,
  input  logic                                                reset,
  input  logic [CHANNELS*sample_buffer_pkg::SAMPLE_WIDTH-1:0] data_in_data,
  input  logic [CHANNELS-1:0]                                 data_in_valid,
  input  sample_buffer_pkg::mode_t                            config_data,
  input  logic                                                config_valid,
  output logic                                                config_ready,
  input  logic [1:0]                                          start_stop_data,
  input  logic                                                start_stop_valid,
  output logic                                                start_stop_ready,
  input  logic                                                start_aux,
  input  logic                                                stop_aux,
  output sample_buffer_pkg::sample_t                          data_out_data,
  output logic                                                data_out_valid,
  output logic                                                data_out_last,
  input  logic                                                data_out_ready,
  output logic                                                capture_started,
  output logic                                                buffer_full
);
  import sample_buffer_pkg::*;

  mode_t               mode;
  logic                capture_en;
  logic [CHANNELS-1:0] seg_active;
  logic [CHANNELS-1:0] bank_full;
  logic                readout_start;
  logic                readout_done;

  bank_port_if #(.BANK_DEPTH(BANK_DEPTH)) bank_port [CHANNELS] ();

  capture_control #(
    .CHANNELS  (CHANNELS),
    .BANK_DEPTH(BANK_DEPTH)
  ) control_i (
    .clk, .reset,
    .config_data, .config_valid, .config_ready,
    .start_stop_data, .start_stop_valid, .start_stop_ready,
    .start_aux, .stop_aux,
    .bank_full, .readout_done,
    .mode, .capture_en, .seg_active, .readout_start,
    .capture_started, .buffer_full
  );

  for (genvar b = 0; b < CHANNELS; b++) begin : g_bank
    sample_bank #(
      .CHANNELS  (CHANNELS),
      .BANK_DEPTH(BANK_DEPTH),
      .BANK_INDEX(b)
    ) bank_i (
      .clk, .reset,
      .data_in_data, .data_in_valid,
      .mode, .capture_en,
      .seg_active   (seg_active[b]),
      .readout_start,
      .rd           (bank_port[b]),
      .full         (bank_full[b])
    );
  end

  bank_readout #(
    .CHANNELS  (CHANNELS),
    .BANK_DEPTH(BANK_DEPTH)
  ) readout_i (
    .clk, .reset,
    .readout_start, .mode,
    .banks(bank_port),
    .data_out_data, .data_out_valid, .data_out_last, .data_out_ready,
    .readout_done
  );

endmodule

`default_nettype wire

// ==== verilog/sample_buffer_pkg.sv ====
// sample buffer package with the sample, mode, command and readout word types
`default_nettype none

package sample_buffer_pkg;

  // header and count words travel in the same word as the samples
  localparam int SAMPLE_WIDTH = 16;

  typedef logic [SAMPLE_WIDTH-1:0] sample_t;

  // banking mode, 2^mode channels enabled
  typedef logic [1:0] mode_t;

  // start/stop command word, start in the upper bit
  typedef struct packed {
    logic start;
    logic stop;
  } cmd_t;

  typedef enum logic [1:0] {
    st_idle,
    st_capture,
    st_readout
  } ctrl_state_t;

  typedef enum logic [1:0] {
    wk_header,
    wk_count,
    wk_sample
  } word_kind_t;

endpackage

`default_nettype wire
